//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;

    // ------------------------------------------------------------------------
    // Major opcodes of the supported RV32I subset
    // ------------------------------------------------------------------------
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // The only SYSTEM encoding the core accepts
    localparam word_t INSTR_EBREAK = 32'h0010_0073;

    localparam alu_op_t ALU_ADD   = 3'd0;
    localparam alu_op_t ALU_SUB   = 3'd1;
    localparam alu_op_t ALU_AND   = 3'd2;
    localparam alu_op_t ALU_OR    = 3'd3;
    localparam alu_op_t ALU_XOR   = 3'd4;
    localparam alu_op_t ALU_PASSB = 3'd5;

    typedef enum logic [2:0] {
        FETCH,
        RS,
        ALU1,
        ALU2,
        ALU3,
        MEM,
        WR,
        HALT
    } core_state_t;

endpackage

`default_nettype wire

//--- design/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] wb_addr_t;
    typedef logic [3:0]  wb_sel_t;

    // Index of a master at the arbiter
    typedef logic [0:0] wb_mst_t;

    localparam wb_mst_t MST_HOST = 1'b0;
    localparam wb_mst_t MST_CORE = 1'b1;

    typedef enum logic [1:0] {
        IDLE,
        HOST,
        CORE
    } arb_state_t;

endpackage

`default_nettype wire

//--- design/rv_regs.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regs
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_write,
    input  word_t    i_data,
    output word_t    o_data1,
    output word_t    o_data2
);

    // x0 has no storage and always reads as zero
    word_t regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_write && i_rd != '0)
        begin
            regs[i_rd] <= i_data;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_data1 <= '0;
            o_data2 <= '0;
        end
        else
        begin
            o_data1 <= (i_rs1 == '0) ? '0 : regs[i_rs1];
            o_data2 <= (i_rs2 == '0) ? '0 : regs[i_rs2];
        end
    end

endmodule

`default_nettype wire

//--- design/rv_exec.sv
`timescale 1ns/10ps
`default_nettype none

module rv_exec
    import rv_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  word_t    i_instr,
    input  word_t    i_pc,
    input  word_t    i_reg1,
    input  word_t    i_reg2,
    output reg_idx_t o_rd,
    output word_t    o_result,
    output word_t    o_addr,
    output logic     o_take,
    output logic     o_load,
    output logic     o_store,
    output logic     o_illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      alu_b;
    word_t      alu_y;
    word_t      base;
    word_t      offset;
    alu_op_t    op;
    logic       writes_rd;
    logic       legal;
    logic       cond;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    always_comb
    begin
        op        = ALU_ADD;
        alu_b     = imm_i;
        offset    = imm_i;
        legal     = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
        OP_IMM:
        begin
            legal     = (funct3 == 3'b000);
            writes_rd = 1'b1;
        end
        OP_REG:
        begin
            alu_b     = i_reg2;
            writes_rd = 1'b1;
            legal     = (funct7 == 7'h00 && funct3 inside {3'b000, 3'b100, 3'b110, 3'b111})
                        || (funct7 == 7'h20 && funct3 == 3'b000);
            case (funct3)
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = funct7[5] ? ALU_SUB : ALU_ADD;
            endcase
        end
        OP_LUI:
        begin
            op        = ALU_PASSB;
            alu_b     = imm_u;
            legal     = 1'b1;
            writes_rd = 1'b1;
        end
        OP_LOAD:
        begin
            legal     = (funct3 == 3'b010);
            writes_rd = 1'b1;
        end
        OP_STORE:
        begin
            offset = imm_s;
            legal  = (funct3 == 3'b010);
        end
        OP_BRANCH:
        begin
            offset = imm_b;
            legal  = (funct3[2:1] == 2'b00);
        end
        OP_JAL:
        begin
            offset    = imm_j;
            legal     = 1'b1;
            writes_rd = 1'b1;
        end
        OP_SYSTEM: legal = (i_instr == INSTR_EBREAK);
        default:   legal = 1'b0;
        endcase
    end

    always_comb
    begin
        case (op)
        ALU_ADD: alu_y = i_reg1 + alu_b;
        ALU_SUB: alu_y = i_reg1 - alu_b;
        ALU_AND: alu_y = i_reg1 & alu_b;
        ALU_OR:  alu_y = i_reg1 | alu_b;
        ALU_XOR: alu_y = i_reg1 ^ alu_b;
        default: alu_y = alu_b;
        endcase
    end

    // BEQ has funct3 000 and BNE 001
    assign cond = funct3[0] ? (i_reg1 != i_reg2) : (i_reg1 == i_reg2);
    assign base = (opcode == OP_BRANCH || opcode == OP_JAL) ? i_pc : i_reg1;

    // One registered stage, settled well before ALU3 ends
    always_ff @(posedge i_clk)
    begin
        o_result <= alu_y;
        o_addr   <= base + offset;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_take <= 1'b0;
        else
            o_take <= (opcode == OP_JAL) || (opcode == OP_BRANCH && cond);
    end

    // Instructions without a destination report rd as x0
    assign o_rd      = writes_rd ? i_instr[11:7] : '0;
    assign o_load    = (opcode == OP_LOAD);
    assign o_store   = (opcode == OP_STORE);
    assign o_illegal = !legal;

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core
    import rv_pkg::*;
    import wb_pkg::*;
#(
    parameter wb_addr_t RESET_ADDR = 32'h0000_0000
)
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_run,
    output wb_addr_t o_wb_adr,
    output word_t    o_wb_dat,
    input  word_t    i_wb_dat,
    output logic     o_wb_we,
    output wb_sel_t  o_wb_sel,
    output logic     o_wb_stb,
    output logic     o_wb_cyc,
    input  logic     i_wb_ack,
    output logic     o_halted,
    output logic     o_illegal
);

    core_state_t state;
    core_state_t state_nxt;

    word_t    pc;
    word_t    pc_p4;
    word_t    instr;
    word_t    result;
    word_t    load_data;
    word_t    wr_data;
    word_t    reg1;
    word_t    reg2;
    word_t    ex_result;
    word_t    ex_addr;
    reg_idx_t ex_rd;
    logic     ex_take;
    logic     ex_load;
    logic     ex_store;
    logic     ex_illegal;
    logic     mem_op;
    logic     is_ebreak;
    logic     is_jal;
    logic     ran;

    assign pc_p4     = pc + 32'd4;
    assign mem_op    = ex_load || ex_store;
    assign is_ebreak = (instr == INSTR_EBREAK);
    assign is_jal    = (instr[6:0] == OP_JAL);

    // ------------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------------

    // The core runs once per reset; after EBREAK or an illegal opcode it stays halted
    always_comb
    begin
        case (state)
        HALT:    state_nxt = (i_run && !ran) ? FETCH : HALT;
        FETCH:   state_nxt = i_wb_ack ? RS : FETCH;
        RS:      state_nxt = (ex_illegal || is_ebreak) ? HALT : ALU1;
        ALU1:    state_nxt = ALU2;
        ALU2:    state_nxt = ALU3;
        ALU3:    state_nxt = MEM;
        MEM:     state_nxt = (!mem_op || i_wb_ack) ? WR : MEM;
        WR:      state_nxt = FETCH;
        default: state_nxt = HALT;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state     <= HALT;
            pc        <= RESET_ADDR;
            ran       <= 1'b0;
            o_illegal <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state != HALT)
                ran <= 1'b1;
            if (state == RS && ex_illegal)
                o_illegal <= 1'b1;
            if (state == WR)
                pc <= ex_take ? ex_addr : pc_p4;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == FETCH && i_wb_ack)
            instr <= i_wb_dat;
        if (state == ALU3)
            result <= ex_result;
        if (state == MEM && i_wb_ack)
            load_data <= i_wb_dat;
    end

    assign o_halted = (state == HALT);

    // JAL links PC+4; every other writer takes the load data or the ALU result
    assign wr_data = ex_load ? load_data : (is_jal ? pc_p4 : result);

    // ------------------------------------------------------------------------
    // Bus master port
    // ------------------------------------------------------------------------
    assign o_wb_stb = (state == FETCH) || (state == MEM && mem_op);
    assign o_wb_cyc = o_wb_stb;
    assign o_wb_adr = (state == MEM) ? ex_addr : pc;
    assign o_wb_we  = (state == MEM) && ex_store;
    assign o_wb_sel = '1;
    assign o_wb_dat = reg2;

    rv_regs u_regs
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_rs1     (instr[19:15]),
        .i_rs2     (instr[24:20]),
        .i_rd      (ex_rd),
        .i_write   (state == WR),
        .i_data    (wr_data),
        .o_data1   (reg1),
        .o_data2   (reg2)
    );

    rv_exec u_exec
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_instr   (instr),
        .i_pc      (pc),
        .i_reg1    (reg1),
        .i_reg2    (reg2),
        .o_rd      (ex_rd),
        .o_result  (ex_result),
        .o_addr    (ex_addr),
        .o_take    (ex_take),
        .o_load    (ex_load),
        .o_store   (ex_store),
        .o_illegal (ex_illegal)
    );

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
    import rv_pkg::*;
    import wb_pkg::*;
#(
    parameter int RAM_ADDR_W = 10
)
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  wb_addr_t              i_h_adr,
    input  word_t                 i_h_dat,
    input  logic                  i_h_we,
    input  wb_sel_t               i_h_sel,
    input  logic                  i_h_stb,
    input  logic                  i_h_cyc,
    output word_t                 o_h_dat,
    output logic                  o_h_ack,
    input  wb_addr_t              i_c_adr,
    input  word_t                 i_c_dat,
    input  logic                  i_c_we,
    input  wb_sel_t               i_c_sel,
    input  logic                  i_c_stb,
    input  logic                  i_c_cyc,
    output word_t                 o_c_dat,
    output logic                  o_c_ack,
    output logic [RAM_ADDR_W-1:0] o_m_adr,
    output word_t                 o_m_dat,
    output logic                  o_m_we,
    output wb_sel_t               o_m_sel,
    output logic                  o_m_stb,
    input  word_t                 i_m_dat,
    input  logic                  i_m_ack
);

    arb_state_t state;
    arb_state_t state_nxt;
    wb_mst_t    owner;
    wb_addr_t   adr;
    logic       h_req;
    logic       c_req;

    assign h_req = i_h_cyc && i_h_stb;
    assign c_req = i_c_cyc && i_c_stb;

    // The host wins a tie; IDLE always separates two grants
    always_comb
    begin
        case (state)
        IDLE:    state_nxt = h_req ? HOST : (c_req ? CORE : IDLE);
        HOST:    state_nxt = i_m_ack ? IDLE : HOST;
        CORE:    state_nxt = i_m_ack ? IDLE : CORE;
        default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // ------------------------------------------------------------------------
    // Request and response routing
    // ------------------------------------------------------------------------
    assign owner = (state == CORE) ? MST_CORE : MST_HOST;

    assign adr     = (owner == MST_CORE) ? i_c_adr : i_h_adr;
    assign o_m_adr = adr[RAM_ADDR_W+1:2];
    assign o_m_dat = (owner == MST_CORE) ? i_c_dat : i_h_dat;
    assign o_m_we  = (owner == MST_CORE) ? i_c_we : i_h_we;
    assign o_m_sel = (owner == MST_CORE) ? i_c_sel : i_h_sel;
    assign o_m_stb = (state == HOST && h_req) || (state == CORE && c_req);

    assign o_h_ack = (state == HOST) && i_m_ack;
    assign o_c_ack = (state == CORE) && i_m_ack;
    assign o_h_dat = (state == HOST) ? i_m_dat : '0;
    assign o_c_dat = (state == CORE) ? i_m_dat : '0;

endmodule

`default_nettype wire

//--- design/wb_ram.sv
`timescale 1ns/10ps
`default_nettype none

module wb_ram
    import rv_pkg::*;
    import wb_pkg::*;
#(
    parameter int RAM_ADDR_W = 10
)
(
    input  logic                  i_clk,
    input  logic [RAM_ADDR_W-1:0] i_adr,
    input  word_t                 i_dat,
    input  logic                  i_we,
    input  wb_sel_t               i_sel,
    input  logic                  i_stb,
    output word_t                 o_dat,
    output logic                  o_ack
);

    word_t mem [0:2**RAM_ADDR_W-1];

    // A strobe still high during its own ack is the same access
    always_ff @(posedge i_clk)
    begin
        o_ack <= i_stb && !o_ack;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_stb && !o_ack)
        begin
            if (i_we)
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (i_sel[lane])
                        mem[i_adr][lane*8 +: 8] <= i_dat[lane*8 +: 8];
                end
            end
            o_dat <= mem[i_adr];
        end
    end

endmodule

`default_nettype wire

//--- design/rv_soc.sv
`timescale 1ns/10ps
`default_nettype none

module rv_soc
    import rv_pkg::*;
    import wb_pkg::*;
#(
    parameter wb_addr_t RESET_ADDR = 32'h0000_0000,
    parameter int       RAM_ADDR_W = 10
)
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_run,
    input  wb_addr_t i_host_adr,
    input  word_t    i_host_dat,
    input  logic     i_host_we,
    input  logic     i_host_stb,
    output word_t    o_host_dat,
    output logic     o_host_ack,
    output logic     o_halted,
    output logic     o_illegal
);

    wb_addr_t              c_adr;
    word_t                 c_dat_w;
    word_t                 c_dat_r;
    logic                  c_we;
    wb_sel_t               c_sel;
    logic                  c_stb;
    logic                  c_cyc;
    logic                  c_ack;
    logic [RAM_ADDR_W-1:0] m_adr;
    word_t                 m_dat_w;
    word_t                 m_dat_r;
    logic                  m_we;
    wb_sel_t               m_sel;
    logic                  m_stb;
    logic                  m_ack;

    rv_core #(
        .RESET_ADDR (RESET_ADDR)
    ) u_core (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_run     (i_run),
        .o_wb_adr  (c_adr),
        .o_wb_dat  (c_dat_w),
        .i_wb_dat  (c_dat_r),
        .o_wb_we   (c_we),
        .o_wb_sel  (c_sel),
        .o_wb_stb  (c_stb),
        .o_wb_cyc  (c_cyc),
        .i_wb_ack  (c_ack),
        .o_halted  (o_halted),
        .o_illegal (o_illegal)
    );

    // Host accesses are whole words, so its cycle follows its strobe
    wb_arbiter #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_arbiter (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_h_adr   (i_host_adr),
        .i_h_dat   (i_host_dat),
        .i_h_we    (i_host_we),
        .i_h_sel   (4'hF),
        .i_h_stb   (i_host_stb),
        .i_h_cyc   (i_host_stb),
        .o_h_dat   (o_host_dat),
        .o_h_ack   (o_host_ack),
        .i_c_adr   (c_adr),
        .i_c_dat   (c_dat_w),
        .i_c_we    (c_we),
        .i_c_sel   (c_sel),
        .i_c_stb   (c_stb),
        .i_c_cyc   (c_cyc),
        .o_c_dat   (c_dat_r),
        .o_c_ack   (c_ack),
        .o_m_adr   (m_adr),
        .o_m_dat   (m_dat_w),
        .o_m_we    (m_we),
        .o_m_sel   (m_sel),
        .o_m_stb   (m_stb),
        .i_m_dat   (m_dat_r),
        .i_m_ack   (m_ack)
    );

    wb_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .i_clk (i_clk),
        .i_adr (m_adr),
        .i_dat (m_dat_w),
        .i_we  (m_we),
        .i_sel (m_sel),
        .i_stb (m_stb),
        .o_dat (m_dat_r),
        .o_ack (m_ack)
    );

endmodule

`default_nettype wire

//--- dv/rv_soc_chk.sv
`timescale 1ns/10ps
`default_nettype none

module rv_soc_chk
    import wb_pkg::*;
#(
    parameter int RAM_ADDR_W = 10
)
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  arb_state_t            i_arb_state,
    input  logic                  i_m_stb,
    input  logic [RAM_ADDR_W-1:0] i_m_adr,
    input  wb_addr_t              i_h_adr,
    input  logic                  i_h_stb,
    input  logic                  i_h_ack,
    input  wb_addr_t              i_c_adr,
    input  logic                  i_c_stb,
    input  logic                  i_c_ack,
    input  logic                  i_halted
);

    logic halted_q;
    logic stopped;

    // Set once the core has come back to a halt, cleared only by reset
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            halted_q <= 1'b1;
            stopped  <= 1'b0;
        end
        else
        begin
            halted_q <= i_halted;
            if (i_halted && !halted_q)
                stopped <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Arbiter
    // ------------------------------------------------------------------------
    stb_from_owner: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_m_stb |->
            ((i_arb_state == HOST && i_h_stb && i_m_adr == i_h_adr[RAM_ADDR_W+1:2])
             || (i_arb_state == CORE && i_c_stb && i_m_adr == i_c_adr[RAM_ADDR_W+1:2])))
        else $error("RAM strobe raised by a master that holds no grant");

    host_ack_own: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_h_ack |-> i_h_stb)
        else $error("host received an ack without its strobe");

    core_ack_own: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_c_ack |-> i_c_stb)
        else $error("core received an ack without its strobe");

    // Once the core has run and stopped, only a reset may restart it
    halted_holds: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        stopped |-> i_halted)
        else $error("halted flag fell without a reset");

endmodule

bind rv_soc rv_soc_chk #(
    .RAM_ADDR_W (RAM_ADDR_W)
) chk0
(
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_arb_state (u_arbiter.state),
    .i_m_stb     (m_stb),
    .i_m_adr     (m_adr),
    .i_h_adr     (i_host_adr),
    .i_h_stb     (i_host_stb),
    .i_h_ack     (o_host_ack),
    .i_c_adr     (c_adr),
    .i_c_stb     (c_stb),
    .i_c_ack     (c_ack),
    .i_halted    (o_halted)
);

`default_nettype wire

//--- dv/tb_rv_soc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_soc;

    localparam int CLK_PERIOD   = 40;
    localparam int INSTR_CYCLES = 40;
    localparam int HOST_CYCLES  = 10;
    // Dynamic instruction counts and host accesses, test by test, with room to spare
    localparam int INSTR_COUNT  = 20 + 40 + 12 + 20 + 4;
    localparam int HOST_COUNT   = 16 + 27 + 14 + 14 + 35 + 6;
    localparam int BUDGET       = INSTR_COUNT * INSTR_CYCLES + HOST_COUNT * HOST_CYCLES + 100;

    logic        clk;
    logic        reset_n;
    logic        run;
    logic [31:0] host_adr;
    logic [31:0] host_dat;
    logic        host_we;
    logic        host_stb;
    logic [31:0] host_rdat;
    logic        host_ack;
    logic        halted;
    logic        illegal;

    logic [31:0] rng;
    logic [31:0] prog [$];
    logic [31:0] xreg [0:31];
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;

    rv_soc dut0
    (
        .i_clk      (clk),
        .i_reset_n  (reset_n),
        .i_run      (run),
        .i_host_adr (host_adr),
        .i_host_dat (host_dat),
        .i_host_we  (host_we),
        .i_host_stb (host_stb),
        .o_host_dat (host_rdat),
        .o_host_ack (host_ack),
        .o_halted   (halted),
        .o_illegal  (illegal)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(BUDGET * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", BUDGET);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ------------------------------------------------------------------------
    // Instruction encoding with the register model alongside
    // ------------------------------------------------------------------------
    function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, 3'b000, rd, 7'h13});
        if (rd != 0)
            xreg[rd] = xreg[rs1] + sext12(imm);
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
        prog.push_back({imm, rd, 7'h37});
        if (rd != 0)
            xreg[rd] = {imm, 12'h000};
    endtask

    // f3 and f7 pick the operation; the model result is given by the caller
    task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] y);
        prog.push_back({f7, rs2, rs1, f3, rd, 7'h33});
        if (rd != 0)
            xreg[rd] = y;
    endtask

    task automatic lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm, rs1, 3'b010, rd, 7'h03});
    endtask

    task automatic sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        prog.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23});
    endtask

    task automatic jal(input logic [4:0] rd, input logic [20:0] off);
        prog.push_back({off[20], off[10:1], off[11], off[19:12], rd, 7'h6F});
    endtask

    task automatic ebreak();
        prog.push_back(32'h0010_0073);
    endtask

    // ------------------------------------------------------------------------
    // Host port and core control
    // ------------------------------------------------------------------------
    task automatic host_access(input logic [31:0] addr, input logic [31:0] data,
                               input logic we, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        host_adr = addr;
        host_dat = data;
        host_we  = we;
        host_stb = 1'b1;
        @(negedge clk);
        while (!host_ack)
            @(negedge clk);
        rdata = host_rdat;
        @(posedge clk);
        #1;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        host_access(addr, data, 1'b1, unused);
    endtask

    task automatic host_read(input logic [31:0] addr, output logic [31:0] data);
        host_access(addr, 32'h0, 1'b0, data);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (int i = 0; i < 32; i++)
            xreg[i] = 32'h0;
    endtask

    task automatic load_program();
        foreach (prog[i])
            host_write(32'(i * 4), prog[i]);
        prog.delete();
    endtask

    task automatic start_core();
        @(posedge clk);
        #1;
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    task automatic wait_halt();
        @(negedge clk);
        while (!halted)
            @(negedge clk);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            $display("error %s exp %h got %h", name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_mem(input logic [31:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        host_read(addr, got);
        check_word($sformatf("host_dat[%h]", addr), exp, got);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, test_errors);
        test_errors = 0;
    endtask

    // Random LUI/ADDI operands, all five register operations, then x1..x8 to 0x404..0x420
    task automatic build_arith();
        logic [31:0] a;
        logic [31:0] b;
        a = next_rand();
        b = next_rand();
        lui(1, a[31:12]);
        addi(1, 1, b[11:0]);
        addi(2, 0, a[11:0]);
        lui(3, b[31:12]);
        addi(3, 3, b[23:12]);
        alu_rr(7'h00, 3'b000, 4, 1, 2, xreg[1] + xreg[2]);
        alu_rr(7'h20, 3'b000, 5, 1, 3, xreg[1] - xreg[3]);
        alu_rr(7'h00, 3'b111, 6, 2, 3, xreg[2] & xreg[3]);
        alu_rr(7'h00, 3'b110, 7, 1, 3, xreg[1] | xreg[3]);
        alu_rr(7'h00, 3'b100, 8, 4, 5, xreg[4] ^ xreg[5]);
        for (int k = 1; k <= 8; k++)
            sw(5'(k), 0, 12'h400 + 12'(k * 4));
        ebreak();
    endtask

    task automatic check_arith();
        logic [31:0] model [1:8];
        for (int k = 1; k <= 8; k++)
            model[k] = xreg[k];
        for (int k = 1; k <= 8; k++)
            check_mem(32'h400 + 32'(k * 4), model[k]);
        check_word("o_illegal", 32'h0, {31'h0, illegal});
    endtask

    initial
    begin
        logic [31:0] addr  [0:7];
        logic [31:0] data  [0:7];
        logic [31:0] got;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        int          sum;

        reset_n  = 1'b0;
        run      = 1'b0;
        host_adr = 32'h0;
        host_dat = 32'h0;
        host_we  = 1'b0;
        host_stb = 1'b0;
        rng      = 32'd66660;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        test_errors = 0;
        reset_dut();

        // Distinct word addresses: the low index bits come from the loop count
        for (int k = 0; k < 8; k++)
        begin
            got     = next_rand();
            addr[k] = {20'h0, got[6:0], 3'(k), 2'b00};
            data[k] = next_rand();
            host_write(addr[k], data[k]);
        end
        for (int k = 0; k < 8; k++)
            check_mem(addr[k], data[k]);
        finish_test("host access");

        reset_dut();
        build_arith();
        load_program();
        start_core();
        wait_halt();
        check_arith();
        finish_test("arithmetic");

        // Count down from n, summing; skipped words would spoil the sum if executed
        reset_dut();
        got = next_rand();
        n   = int'(got % 8) + 1;
        addi(1, 0, 12'(n));
        addi(2, 0, 12'h000);
        alu_rr(7'h00, 3'b000, 2, 2, 1, xreg[2] + xreg[1]);
        addi(1, 1, 12'hFFF);
        prog.push_back(btype(13'h1FF8, 0, 1, 3'b001));
        prog.push_back(btype(13'd8, 0, 0, 3'b000));
        addi(2, 0, 12'h7FF);
        jal(3, 21'd8);
        addi(2, 0, 12'h001);
        sw(2, 0, 12'h400);
        sw(3, 0, 12'h404);
        ebreak();
        load_program();
        start_core();
        wait_halt();
        sum = 0;
        for (int i = 1; i <= n; i++)
            sum += i;
        check_mem(32'h400, 32'(sum));
        check_mem(32'h404, 32'd32);
        finish_test("control flow");

        reset_dut();
        a = next_rand();
        b = next_rand();
        host_write(32'h600, a);
        host_write(32'h604, b);
        lw(1, 0, 12'h600);
        lw(2, 0, 12'h604);
        xreg[1] = a;
        xreg[2] = b;
        alu_rr(7'h00, 3'b000, 3, 1, 2, a + b);
        addi(0, 1, 12'h005);
        sw(3, 0, 12'h400);
        sw(0, 0, 12'h404);
        alu_rr(7'h00, 3'b000, 4, 0, 1, a);
        sw(4, 0, 12'h408);
        ebreak();
        load_program();
        start_core();
        wait_halt();
        check_mem(32'h400, a + b);
        check_mem(32'h404, 32'h0);
        check_mem(32'h408, a);
        finish_test("loads");

        // Host traffic to 0x800 while the core runs
        reset_dut();
        build_arith();
        load_program();
        start_core();
        for (int k = 0; k < 4; k++)
        begin
            data[k] = next_rand();
            host_write(32'h800 + 32'(k * 4), data[k]);
        end
        for (int k = 0; k < 4; k++)
            check_mem(32'h800 + 32'(k * 4), data[k]);
        wait_halt();
        check_arith();
        finish_test("contention");

        reset_dut();
        a = next_rand();
        host_write(32'h40C, a);
        addi(1, 0, 12'h055);
        prog.push_back(32'h0000_000B);
        sw(1, 0, 12'h40C);
        ebreak();
        load_program();
        start_core();
        wait_halt();
        check_word("o_illegal", 32'h1, {31'h0, illegal});
        check_mem(32'h40C, a);
        // The core must still be halted after the host read
        check_word("o_halted", 32'h1, {31'h0, halted});
        finish_test("illegal opcode");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/rv_pkg.sv
design/wb_pkg.sv
design/rv_regs.sv
design/rv_exec.sv
design/rv_core.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/rv_soc.sv
dv/rv_soc_chk.sv
dv/tb_rv_soc.sv

//--- Makefile
BIN := obj_dir/Vtb_rv_soc

.PHONY: all run clean

all: run

$(BIN): list.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing --assert -f list.f --top-module tb_rv_soc -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
